// ==== kbd_defs.svh ====
`ifndef KBD_DEFS_SVH
`define KBD_DEFS_SVH

// ps2 frame: start, 8 data bits, odd parity, stop
`define PS2_FRAME_BITS 11

// receiver byte queue depth, power of two
`define KBD_FIFO_DEPTH 4

// stable samples before a ps2_clk level is taken
`define KBD_FILTER_LEN 8

// keyboard matrix size
`define KBD_ROWS 8
`define KBD_COLS 8

`endif

// ==== key_map_if.sv ====
interface key_map_if;

	// code under lookup, held by key_matrix
	logic [7:0] scancode;
	logic shift_held;
	logic mod_rus;

	// registered lookup result, one clock behind scancode
	matrix_pkg::matrix_pos_t pos;

	modport key_matrix (
		output scancode,
		output shift_held,
		output mod_rus,
		input  pos
	);

	modport mapper (
		input  scancode,
		input  shift_held,
		input  mod_rus,
		output pos
	);

endinterface

// ==== key_matrix.sv ====
`include "kbd_defs.svh"

module key_matrix (
	input  logic                 clkk,
	input  logic                 reset,
	output logic                 rden,
	input  logic [7:0]           q,
	input  logic                 dsr,
	key_map_if.key_matrix        map,
	input  logic                 mod_rus,
	input  logic [`KBD_ROWS-1:0] rowselect,
	output logic [`KBD_COLS-1:0] rowbits,
	output logic                 key_shift,
	output logic                 key_ctrl,
	output logic                 key_rus,
	output logic                 key_blksbr
);
	import ps2_pkg::*;
	import matrix_pkg::*;

	key_state_t state;
	logic [`KBD_COLS-1:0] matrix [`KBD_ROWS];
	logic [`KBD_COLS-1:0] tmp;
	logic [`KBD_COLS-1:0] col_onehot;
	logic [`KBD_COLS-1:0] row_or;
	logic [7:0] code;
	logic shift_held;
	logic shift_ovr;

	// byte under decode is held here, the fifo head moves on after the pop
	assign map.scancode = code;
	assign map.shift_held = shift_held;
	assign map.mod_rus = mod_rus;

	always_comb begin
		for (int c = 0; c < `KBD_COLS; c++)
			col_onehot[c] = map.pos.col == 3'(c);
	end

	always_ff @(posedge clkk) begin
		if (reset) begin
			state <= ks_latch_row;
			rden <= 1'b0;
			shift_held <= 1'b0;
			shift_ovr <= 1'b0;
			key_ctrl <= 1'b0;
			key_rus <= 1'b0;
			key_blksbr <= 1'b0;
			for (int r = 0; r < `KBD_ROWS; r++)
				matrix[r] <= '0;
		end else begin
			case (state)
				// entry point after reset and after every event
				ks_latch_row: begin
					rden <= 1'b0;
					state <= ks_wait_make;
				end
				ks_wait_make: begin
					if (dsr) begin
						code <= q;
						rden <= 1'b1;
						state <= ks_pop;
					end
				end
				ks_pop: begin
					rden <= 1'b0;
					state <= ks_settle;
				end
				// mapper result lands during this cycle
				ks_settle: state <= ks_decide;
				ks_decide: begin
					if (code == sc_break) begin
						state <= ks_wait_break;
					end else begin
						tmp <= matrix[map.pos.row];
						state <= ks_apply_make;
					end
				end
				ks_apply_make: begin
					case (code)
						sc_lshift, sc_rshift: shift_held <= 1'b1;
						sc_ctrl: key_ctrl <= 1'b1;
						sc_rus: key_rus <= 1'b1;
						sc_blksbr: key_blksbr <= 1'b1;
						// extended prefix and overrun are swallowed
						sc_extended, sc_error: ;
						default: begin
							if (!map.pos.neo) begin
								matrix[map.pos.row] <= tmp | col_onehot;
								shift_ovr <= map.pos.shift;
							end
						end
					endcase
					state <= ks_latch_row;
				end
				// F0 seen, the released key follows
				ks_wait_break: begin
					if (dsr) begin
						code <= q;
						rden <= 1'b1;
						state <= ks_pop_break;
					end
				end
				ks_pop_break: begin
					rden <= 1'b0;
					state <= ks_settle_break;
				end
				ks_settle_break: state <= ks_load_break;
				ks_load_break: begin
					tmp <= matrix[map.pos.row];
					state <= ks_apply_break;
				end
				ks_apply_break: begin
					case (code)
						sc_lshift, sc_rshift: shift_held <= 1'b0;
						sc_ctrl: key_ctrl <= 1'b0;
						sc_rus: key_rus <= 1'b0;
						sc_blksbr: key_blksbr <= 1'b0;
						sc_extended, sc_error: ;
						default: begin
							if (!map.pos.neo) begin
								matrix[map.pos.row] <= tmp & ~col_onehot;
								shift_ovr <= 1'b0;
							end
						end
					endcase
					state <= ks_latch_row;
				end
				default: state <= ks_latch_row;
			endcase
		end
	end

	// host sees shift inverted while an override key is down
	assign key_shift = shift_held ^ shift_ovr;

	// several rows may be selected at once
	always_comb begin
		row_or = '0;
		for (int r = 0; r < `KBD_ROWS; r++) begin
			if (rowselect[r])
				row_or = row_or | matrix[r];
		end
	end

	always_ff @(posedge clkk) begin
		if (reset)
			rowbits <= '0;
		else
			rowbits <= row_or;
	end

endmodule

// ==== matrix_pkg.sv ====
package matrix_pkg;

	// make/break event sequencer
	typedef enum logic [3:0] {
		ks_latch_row,
		ks_wait_make,
		ks_pop,
		ks_settle,
		ks_decide,
		ks_apply_make,
		ks_wait_break,
		ks_pop_break,
		ks_settle_break,
		ks_load_break,
		ks_apply_break
	} key_state_t;

	// result of the scan code lookup
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
		// forces shift on the host side while the key is down
		logic       shift;
		// not in matrix
		logic       neo;
	} matrix_pos_t;

endpackage

// ==== ps2_pkg.sv ====
package ps2_pkg;

	// frame receiver states
	typedef enum logic [1:0] {
		rx_idle,
		rx_data,
		rx_parity,
		rx_stop
	} rx_state_t;

	// scan codes handled outside the matrix table
	typedef enum logic [7:0] {
		sc_break    = 8'hf0,
		sc_extended = 8'he0,
		sc_error    = 8'hff,
		sc_lshift   = 8'h12,
		sc_rshift   = 8'h59,
		sc_ctrl     = 8'h14,
		// caps lock key acts as rus/lat
		sc_rus      = 8'h58,
		// f12 acts as block-break
		sc_blksbr   = 8'h07
	} scan_special_t;

endpackage

// ==== ps2_receiver.sv ====
`include "kbd_defs.svh"

module ps2_receiver (
	input  logic       clkk,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_dat,
	input  logic       rden,
	output logic [7:0] q,
	output logic       dsr
);
	import ps2_pkg::*;

	localparam int filt_w = $clog2(`KBD_FILTER_LEN);
	localparam int ptr_w = $clog2(`KBD_FIFO_DEPTH);

	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic [filt_w-1:0] filt_cnt;
	logic clk_filt;
	logic clk_filt_d;
	logic fall;

	rx_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic parity_ok;
	logic push;

	logic [7:0] mem [`KBD_FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic pop;
	logic full;

	// both lines idle high
	always_ff @(posedge clkk) begin
		if (reset) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
		end
	end

	// a new clock level must hold for the full filter length
	always_ff @(posedge clkk) begin
		if (reset) begin
			filt_cnt <= '0;
			clk_filt <= 1'b1;
			clk_filt_d <= 1'b1;
		end else begin
			clk_filt_d <= clk_filt;
			if (clk_sync[1] == clk_filt) begin
				filt_cnt <= '0;
			end else if (filt_cnt == filt_w'(`KBD_FILTER_LEN - 1)) begin
				clk_filt <= clk_sync[1];
				filt_cnt <= '0;
			end else begin
				filt_cnt <= filt_cnt + 1'b1;
			end
		end
	end

	assign fall = clk_filt_d & ~clk_filt;

	// frame sequencer, data arrives lsb first
	always_ff @(posedge clkk) begin
		if (reset) begin
			state <= rx_idle;
			bit_cnt <= '0;
			parity_ok <= 1'b0;
		end else if (fall) begin
			case (state)
				rx_idle: begin
					// start bit is low
					if (!dat_sync[1]) begin
						bit_cnt <= '0;
						state <= rx_data;
					end
				end
				rx_data: begin
					shreg <= {dat_sync[1], shreg[7:1]};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'(`PS2_FRAME_BITS - 4))
						state <= rx_parity;
				end
				rx_parity: begin
					parity_ok <= ^{shreg, dat_sync[1]};
					state <= rx_stop;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// good frame goes in on the stop bit edge, dropped when the queue is full
	assign push = fall && state == rx_stop && dat_sync[1] && parity_ok && !full;
	assign pop = rden && dsr;
	assign full = count == (ptr_w + 1)'(`KBD_FIFO_DEPTH);

	always_ff @(posedge clkk) begin
		if (push)
			mem[wr_ptr] <= shreg;
	end

	always_ff @(posedge clkk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// show-ahead head byte
	assign q = mem[rd_ptr];
	assign dsr = count != '0;

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_vector_keyboard -o sim_kbd \
	&& ./obj_dir/sim_kbd \
	|| exit 1

// ==== scan_to_matrix.sv ====
module scan_to_matrix (
	input logic clkk,
	key_map_if.mapper map
);
	import matrix_pkg::*;

	// {row, col} in octal, one digit each
	logic [5:0] rc;
	logic neo;
	logic shift;
	matrix_pos_t next_pos;

	always_comb begin
		neo = 1'b0;
		case (map.scancode)
			// row 2, digits 0 to 7
			8'h45: rc = 6'o20;
			8'h16: rc = 6'o21;
			8'h1e: rc = 6'o22;
			8'h26: rc = 6'o23;
			8'h25: rc = 6'o24;
			8'h2e: rc = 6'o25;
			8'h36: rc = 6'o26;
			8'h3d: rc = 6'o27;
			// row 4, apostrophe then a to g
			8'h52: rc = 6'o40;
			8'h1c: rc = 6'o41;
			8'h32: rc = 6'o42;
			8'h21: rc = 6'o43;
			8'h23: rc = 6'o44;
			8'h24: rc = 6'o45;
			8'h2b: rc = 6'o46;
			8'h34: rc = 6'o47;
			// row 5, h to o
			8'h33: rc = 6'o50;
			8'h43: rc = 6'o51;
			8'h3b: rc = 6'o52;
			8'h42: rc = 6'o53;
			8'h4b: rc = 6'o54;
			8'h3a: rc = 6'o55;
			8'h31: rc = 6'o56;
			8'h44: rc = 6'o57;
			// row 6, p to w
			8'h4d: rc = 6'o60;
			8'h15: rc = 6'o61;
			8'h2d: rc = 6'o62;
			8'h1b: rc = 6'o63;
			8'h2c: rc = 6'o64;
			8'h3c: rc = 6'o65;
			8'h2a: rc = 6'o66;
			8'h1d: rc = 6'o67;
			// row 7, x y z brackets backslash equals space
			8'h22: rc = 6'o70;
			8'h35: rc = 6'o71;
			8'h1a: rc = 6'o72;
			8'h54: rc = 6'o73;
			8'h5d: rc = 6'o74;
			8'h5b: rc = 6'o75;
			8'h55: rc = 6'o76;
			8'h29: rc = 6'o77;
			default: begin
				rc = 6'o00;
				neo = 1'b1;
			end
		endcase
	end

	// apostrophe always needs shift on the host keyboard.
	// in rus mode the letter rows take the live shift state
	always_comb begin
		if (map.scancode == 8'h52)
			shift = 1'b1;
		else if (map.mod_rus && !neo && rc[5:3] >= 3'd4)
			shift = map.shift_held;
		else
			shift = 1'b0;
	end

	always_comb begin
		next_pos.row = rc[5:3];
		next_pos.col = rc[2:0];
		next_pos.shift = shift;
		next_pos.neo = neo;
	end

	always_ff @(posedge clkk) begin
		map.pos <= next_pos;
	end

endmodule

// ==== tb.f ====
+incdir+.
ps2_pkg.sv
matrix_pkg.sv
key_map_if.sv
ps2_receiver.sv
scan_to_matrix.sv
key_matrix.sv
vector_keyboard.sv
tb_vector_keyboard.sv

// ==== tb_vector_keyboard.sv ====
`include "kbd_defs.svh"

module tb_vector_keyboard;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_bit = 40;
	localparam int frame_gap = 20;
	localparam int settle_wait = 30;
	localparam int num_events = 150;
	localparam int frame_cycles = `PS2_FRAME_BITS * 2 * half_bit + frame_gap;
	localparam int check_cycles = settle_wait + 12 * 2 + 4;
	// worst event is a bad frame, a break prefix and the code itself
	localparam int event_cycles = 3 * (frame_cycles + check_cycles);
	localparam int limit_cycles = 16 + 256 * 2 + 64 + num_events * event_cycles;

	// model copy of the mapping table as row 2 then rows 4 to 7 with columns 0 to 7
	localparam logic [319:0] key_codes = {
		8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d,
		8'h52, 8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34,
		8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44,
		8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d,
		8'h22, 8'h35, 8'h1a, 8'h54, 8'h5d, 8'h5b, 8'h55, 8'h29
	};
	// lshift, rshift, ctrl, rus, blksbr
	localparam logic [39:0] special_codes = {8'h12, 8'h59, 8'h14, 8'h58, 8'h07};
	// f1, tab, backspace, esc, enter
	localparam logic [39:0] other_codes = {8'h05, 8'h0d, 8'h66, 8'h76, 8'h5a};

	logic clkk;
	logic reset;
	logic ps2_clk;
	logic ps2_dat;
	logic mod_rus;
	logic [7:0] rowselect;
	logic [7:0] rowbits;
	logic key_shift;
	logic key_ctrl;
	logic key_rus;
	logic key_blksbr;

	logic [31:0] rng_state;
	logic [7:0] m_rows [8];
	logic m_shift_held;
	logic m_shift_ovr;
	logic m_ctrl;
	logic m_rus;
	logic m_blksbr;

	vector_keyboard u_dut (
		.clkk       (clkk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.mod_rus    (mod_rus),
		.rowselect  (rowselect),
		.rowbits    (rowbits),
		.key_shift  (key_shift),
		.key_ctrl   (key_ctrl),
		.key_rus    (key_rus),
		.key_blksbr (key_blksbr)
	);

	initial begin
		clkk = 1'b0;
		forever #2 clkk = ~clkk;
	end

	initial begin
		#(limit_cycles * 4 * 2);
		$display("Verification failed");
		$fatal(1, "watchdog expired, the run did not finish in time");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_below(input int n);
		rng_state = xorshift32(rng_state);
		return int'(rng_state[15:0]) % n;
	endfunction

	// entry 0 is the leftmost byte of a right aligned list
	function automatic logic [7:0] byte_of(input logic [319:0] list, input int count,
			input int i);
		return list[8 * (count - 1 - i) +: 8];
	endfunction

	function automatic int find_key(input logic [7:0] code);
		for (int i = 0; i < 40; i++) begin
			if (byte_of(key_codes, 40, i) == code)
				return i;
		end
		return -1;
	endfunction

	function automatic logic [7:0] expected_rows(input logic [7:0] sel);
		logic [7:0] acc;
		acc = '0;
		for (int r = 0; r < 8; r++) begin
			if (sel[r])
				acc = acc | m_rows[r];
		end
		return acc;
	endfunction

	task automatic compare(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (expected !== actual) begin
			$display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			$display("Verification failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clkk);
	endtask

	// device side drives data while the clock is high
	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~^data ^ bad_parity, data, 1'b0};
		for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
			@(negedge clkk);
			ps2_dat = bits[i];
			wait_cycles(half_bit);
			ps2_clk = 1'b0;
			wait_cycles(half_bit);
			ps2_clk = 1'b1;
		end
		wait_cycles(frame_gap);
	endtask

	task automatic update_model(input logic [7:0] code, input logic is_break);
		int idx;
		int row;
		idx = find_key(code);
		case (code)
			8'h12, 8'h59: m_shift_held = !is_break;
			8'h14: m_ctrl = !is_break;
			8'h58: m_rus = !is_break;
			8'h07: m_blksbr = !is_break;
			8'he0, 8'hff: ;
			default: begin
				if (idx >= 0) begin
					row = idx < 8 ? 2 : idx / 8 + 3;
					m_rows[row][idx % 8] = !is_break;
					if (is_break)
						m_shift_ovr = 1'b0;
					else if (code == 8'h52)
						m_shift_ovr = 1'b1;
					else if (mod_rus && row >= 4)
						m_shift_ovr = m_shift_held;
					else
						m_shift_ovr = 1'b0;
				end
			end
		endcase
	endtask

	task automatic check_rows(input logic [7:0] sel);
		@(negedge clkk);
		rowselect = sel;
		@(negedge clkk);
		compare("rowbits", expected_rows(sel), rowbits);
	endtask

	task automatic check_flags();
		compare("key_shift", {7'b0, m_shift_held ^ m_shift_ovr}, {7'b0, key_shift});
		compare("key_ctrl", {7'b0, m_ctrl}, {7'b0, key_ctrl});
		compare("key_rus", {7'b0, m_rus}, {7'b0, key_rus});
		compare("key_blksbr", {7'b0, m_blksbr}, {7'b0, key_blksbr});
	endtask

	task automatic check_all();
		for (int r = 0; r < 8; r++)
			check_rows(8'(1 << r));
		check_rows(8'hff);
		repeat (3) check_rows(8'(rand_below(256)));
		check_flags();
	endtask

	task automatic run_event();
		int kind;
		logic [7:0] code;
		logic brk;
		if (rand_below(4) == 0) begin
			@(negedge clkk);
			mod_rus = ~mod_rus;
		end
		kind = rand_below(8);
		case (kind)
			4: code = byte_of(320'(special_codes), 5, rand_below(5));
			5: code = rand_below(2) != 0 ? 8'he0 : 8'hff;
			6: code = byte_of(320'(other_codes), 5, rand_below(5));
			default: code = byte_of(key_codes, 40, rand_below(40));
		endcase
		// a corrupted copy goes first and must leave no trace
		if (rand_below(10) == 0) begin
			send_frame(code, 1'b1);
			wait_cycles(settle_wait);
			check_all();
		end
		brk = rand_below(2) != 0;
		if (brk) begin
			send_frame(8'hf0, 1'b0);
			wait_cycles(settle_wait);
			check_all();
		end
		send_frame(code, 1'b0);
		update_model(code, brk);
		wait_cycles(settle_wait);
		check_all();
	endtask

	initial begin
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		mod_rus = 1'b0;
		rowselect = '0;
		rng_state = 32'd61003;
		m_shift_held = 1'b0;
		m_shift_ovr = 1'b0;
		m_ctrl = 1'b0;
		m_rus = 1'b0;
		m_blksbr = 1'b0;
		for (int r = 0; r < 8; r++)
			m_rows[r] = '0;
		repeat (16) @(posedge clkk);
		@(negedge clkk);
		reset = 1'b0;
		wait_cycles(4);
		// empty matrix for every select pattern
		for (int p = 0; p < 256; p++)
			check_rows(8'(p));
		check_flags();
		for (int n = 0; n < num_events; n++)
			run_event();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== vector_keyboard.sv ====
module vector_keyboard (
	input  logic       clkk,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_dat,
	input  logic       mod_rus,
	input  logic [7:0] rowselect,
	output logic [7:0] rowbits,
	output logic       key_shift,
	output logic       key_ctrl,
	output logic       key_rus,
	output logic       key_blksbr
);

	logic rden;
	logic dsr;
	logic [7:0] q;

	key_map_if map_bus ();

	ps2_receiver u_receiver (
		.clkk    (clkk),
		.reset   (reset),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat),
		.rden    (rden),
		.q       (q),
		.dsr     (dsr)
	);

	scan_to_matrix u_mapper (
		.clkk (clkk),
		.map  (map_bus.mapper)
	);

	key_matrix u_matrix (
		.clkk       (clkk),
		.reset      (reset),
		.rden       (rden),
		.q          (q),
		.dsr        (dsr),
		.map        (map_bus.key_matrix),
		.mod_rus    (mod_rus),
		.rowselect  (rowselect),
		.rowbits    (rowbits),
		.key_shift  (key_shift),
		.key_ctrl   (key_ctrl),
		.key_rus    (key_rus),
		.key_blksbr (key_blksbr)
	);

endmodule
